/* Bender.yml */
package:
  name: udp_tx

sources:
  - eth_udp_pkg.sv
  - phy_tick_gen.sv
  - ip_checksum.sv
  - udp_frame_reg.sv
  - udp_tx_ctrl.sv
  - udp_tx_top.sv
  - target: simulation
    files:
      - tb_udp_tx.sv

/* eth_udp_pkg.sv */
`default_nettype none

package eth_udp_pkg;

    // Payload bytes carried by every frame.
    localparam int unsigned PAYLOAD_BYTES = 4;

    // System clock cycles per PHY nibble slot.
    localparam int unsigned TICK_DIVIDER = 4;

    // Interframe gap, counted in PHY ticks.
    localparam int unsigned GAP_NIBBLES = 24;

    // IPv4 and UDP header sizes in bytes.
    localparam int unsigned IP_HEADER_BYTES  = 20;
    localparam int unsigned UDP_HEADER_BYTES = 8;
    localparam int unsigned UDP_TOTAL_BYTES  = UDP_HEADER_BYTES + PAYLOAD_BYTES;
    localparam int unsigned IP_TOTAL_BYTES   = IP_HEADER_BYTES + UDP_TOTAL_BYTES;

    // Preamble and SFD (8 bytes), Ethernet header (14 bytes), then the IP packet.
    localparam int unsigned FRAME_NIBBLES = 2 * (8 + 14 + IP_TOTAL_BYTES);
    localparam int unsigned FRAME_BITS    = 4 * FRAME_NIBBLES;

    // Bit position of the IP header inside the frame register.
    localparam int unsigned IP_HEADER_LSB = 8 * UDP_TOTAL_BYTES;

    // Bit position of the checksum field inside the IP header.
    localparam int unsigned IP_CHECKSUM_LSB = 64;

    // Fixed frame fields.
    localparam logic [7:0]  PREAMBLE_BYTE   = 8'hAA;
    localparam logic [7:0]  SFD_BYTE        = 8'hAB;
    localparam logic [15:0] ETHER_TYPE_IPV4 = 16'h0800;
    localparam logic [3:0]  IP_VERSION      = 4'd4;
    localparam logic [3:0]  IP_IHL          = 4'd5;
    // Requests high throughput and reliability.
    localparam logic [7:0]  IP_TOS          = 8'h0C;
    localparam logic [15:0] IP_ID           = 16'h0000;
    localparam logic [2:0]  IP_FLAGS        = 3'b000;
    localparam logic [12:0] IP_FRAG_OFFSET  = 13'd0;
    localparam logic [7:0]  IP_TTL          = 8'hFF;
    localparam logic [7:0]  IP_PROTOCOL_UDP = 8'h11;

    // Address, port and payload types.
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [8*PAYLOAD_BYTES-1:0] payload_t;

    // Header, checksum and PHY data types.
    typedef logic [8*IP_HEADER_BYTES-1:0] ip_header_t;
    typedef logic [15:0] checksum_t;
    typedef logic [3:0] nibble_t;
    typedef logic [FRAME_BITS-1:0] frame_t;

    // Counter types.
    typedef logic [$clog2(FRAME_NIBBLES+1)-1:0] nibble_count_t;
    typedef logic [$clog2(GAP_NIBBLES+1)-1:0] gap_count_t;
    typedef logic [$clog2(TICK_DIVIDER)-1:0] tick_count_t;

    // Terminal counts.
    localparam nibble_count_t LAST_NIBBLE    = nibble_count_t'(FRAME_NIBBLES - 1);
    localparam gap_count_t    LAST_GAP_TICK  = gap_count_t'(GAP_NIBBLES - 1);
    localparam tick_count_t   LAST_TICK_COUNT = tick_count_t'(TICK_DIVIDER - 1);

    // Transmit control states.
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_CHECKSUM,
        TX_SEND,
        TX_GAP
    } tx_state_t;

endpackage

`default_nettype wire

/* files.f */
eth_udp_pkg.sv
phy_tick_gen.sv
ip_checksum.sv
udp_frame_reg.sv
udp_tx_ctrl.sv
udp_tx_top.sv
tb_udp_tx.sv

/* ip_checksum.sv */
`timescale 1ns/1ps
`default_nettype none

module ip_checksum (
    input  wire eth_udp_pkg::ip_header_t ip_header,
    output eth_udp_pkg::checksum_t       checksum
);

    // Header copy with the checksum field cleared.
    eth_udp_pkg::ip_header_t masked_header;

    // Ten 16 bit words need four carry bits.
    logic [19:0] word_sum;

    // Carry folding stages.
    logic [16:0] fold_once;
    logic [15:0] fold_twice;

    // Sum all header words.
    // The checksum field counts as zero here.
    always_comb begin
        masked_header = ip_header;
        masked_header[eth_udp_pkg::IP_CHECKSUM_LSB +: 16] = '0;
        word_sum = '0;
        for (int i = 0; i < eth_udp_pkg::IP_HEADER_BYTES / 2; i++) begin
            word_sum = word_sum + 20'(masked_header[16*i +: 16]);
        end
    end

    // First fold adds the upper carries back into the low word.
    assign fold_once = {1'b0, word_sum[15:0]} + 17'(word_sum[19:16]);

    // Second fold catches the carry out of the first one.
    assign fold_twice = fold_once[15:0] + 16'(fold_once[16]);

    // One's complement of the folded sum.
    assign checksum = ~fold_twice;

endmodule

`default_nettype wire

/* phy_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module phy_tick_gen (
    input  wire  clk,
    input  wire  reset,
    output logic tick
);

    // Position inside the current PHY slot.
    eth_udp_pkg::tick_count_t count;

    // Free running divider.
    // The tick is registered so it lasts exactly one clk cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            tick <= (count == eth_udp_pkg::LAST_TICK_COUNT);
            if (count == eth_udp_pkg::LAST_TICK_COUNT) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Nibble hold time in the controller relies on isolated ticks.
    tick_single_cycle: assert property (
        @(posedge clk) disable iff (reset) tick |=> !tick
    );

endmodule

`default_nettype wire

/* tb_udp_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_udp_tx;

    localparam int unsigned CLK_PERIOD_NS = 4;

    // Frames sent over the whole run.
    localparam int unsigned FRAME_COUNT = 8;

    // Frame, gap and start latency in ticks with a margin of two.
    localparam int unsigned WATCHDOG_NS = 2 * FRAME_COUNT *
        (eth_udp_pkg::FRAME_NIBBLES + eth_udp_pkg::GAP_NIBBLES + 4) *
        eth_udp_pkg::TICK_DIVIDER * CLK_PERIOD_NS;

    // Preamble and SFD, Ethernet header, then ten bytes into the IP header.
    localparam int unsigned CSUM_FIRST_NIBBLE = 2 * (8 + 14 + 10);
    localparam int unsigned CSUM_LAST_NIBBLE  = CSUM_FIRST_NIBBLE + 3;

    logic                   clk;
    logic                   reset;
    logic                   send;
    eth_udp_pkg::payload_t  payload;
    eth_udp_pkg::mac_addr_t src_mac;
    eth_udp_pkg::mac_addr_t dest_mac;
    eth_udp_pkg::ip_addr_t  src_ip;
    eth_udp_pkg::ip_addr_t  dest_ip;
    eth_udp_pkg::udp_port_t src_port;
    eth_udp_pkg::udp_port_t dest_port;
    logic                   ready;
    logic                   tx_en;
    eth_udp_pkg::nibble_t   tx_d;

    // Expected frame and checksum for the frame in flight.
    eth_udp_pkg::frame_t    exp_frame;
    eth_udp_pkg::checksum_t exp_csum;

    // LCG state.
    logic [31:0] rand_state = 32'he35ee1f5;

    udp_tx_top i_dut (
        .clk      (clk),
        .reset    (reset),
        .send     (send),
        .payload  (payload),
        .src_mac  (src_mac),
        .dest_mac (dest_mac),
        .src_ip   (src_ip),
        .dest_ip  (dest_ip),
        .src_port (src_port),
        .dest_port(dest_port),
        .ready    (ready),
        .tx_en    (tx_en),
        .tx_d     (tx_d)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    // Guards against a hung handshake.
    initial begin
        #(WATCHDOG_NS);
        abort_run("The run timed out before all tests finished.");
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped after a failure.");
    endtask

    task automatic check_nibble(input string name, input eth_udp_pkg::nibble_t got,
                                input eth_udp_pkg::nibble_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %t %s = %h, expected %h", $realtime, name, got, exp));
        end
    endtask

    task automatic check_checksum(input string name, input eth_udp_pkg::checksum_t got,
                                  input eth_udp_pkg::checksum_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %t %s = %h, expected %h", $realtime, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %t %s = %b, expected %b", $realtime, name, got, exp));
        end
    endtask

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // IPv4 header with a zero checksum field.
    function automatic eth_udp_pkg::ip_header_t build_header(input eth_udp_pkg::ip_addr_t s,
                                                             input eth_udp_pkg::ip_addr_t d);
        return {eth_udp_pkg::IP_VERSION, eth_udp_pkg::IP_IHL, eth_udp_pkg::IP_TOS,
                16'(eth_udp_pkg::IP_TOTAL_BYTES), eth_udp_pkg::IP_ID, eth_udp_pkg::IP_FLAGS,
                eth_udp_pkg::IP_FRAG_OFFSET, eth_udp_pkg::IP_TTL, eth_udp_pkg::IP_PROTOCOL_UDP,
                16'h0000, s, d};
    endfunction

    // One's complement sum of the header words without the checksum word.
    function automatic eth_udp_pkg::checksum_t header_checksum(input eth_udp_pkg::ip_header_t h);
        int unsigned sum;
        sum = 0;
        for (int i = 0; i < 10; i++) begin
            if (i != 5) begin
                sum = sum + h[159 - 16*i -: 16];
            end
        end
        while ((sum >> 16) != 0) begin
            sum = (sum & 32'h0000_ffff) + (sum >> 16);
        end
        return ~sum[15:0];
    endfunction

    // Model of the frame built from the current inputs.
    task automatic build_expected();
        eth_udp_pkg::ip_header_t header;
        header = build_header(src_ip, dest_ip);
        exp_csum = header_checksum(header);
        header[79:64] = exp_csum;
        exp_frame = {{7{eth_udp_pkg::PREAMBLE_BYTE}}, eth_udp_pkg::SFD_BYTE, dest_mac, src_mac,
                     eth_udp_pkg::ETHER_TYPE_IPV4, header, src_port, dest_port,
                     16'(eth_udp_pkg::UDP_TOTAL_BYTES), 16'h0000, payload};
    endtask

    task automatic randomize_inputs();
        logic [31:0] hi;
        logic [31:0] lo;
        payload = next_rand();
        hi = next_rand();
        lo = next_rand();
        src_mac = {hi[15:0], lo};
        hi = next_rand();
        lo = next_rand();
        dest_mac = {hi[15:0], lo};
        src_ip = next_rand();
        dest_ip = next_rand();
        hi = next_rand();
        src_port = hi[31:16];
        dest_port = hi[15:0];
    endtask

    // Waits for ready, then one send pulse.
    task automatic start_frame();
        @(posedge clk);
        #0.5;
        while (ready !== 1'b1) begin
            @(posedge clk);
            #0.5;
        end
        send = 1'b1;
        @(posedge clk);
        #0.5;
        send = 1'b0;
        check_bit("ready", ready, 1'b0);
    endtask

    // Samples every nibble mid-slot and compares it with the model.
    task automatic capture_frame();
        int unsigned waited;
        eth_udp_pkg::checksum_t got_csum;
        waited = 0;
        got_csum = '0;
        @(posedge clk);
        #1;
        while (tx_en !== 1'b1) begin
            waited++;
            if (waited > 4 * eth_udp_pkg::TICK_DIVIDER) begin
                abort_run("tx_en did not rise after a send was accepted.");
            end
            @(posedge clk);
            #1;
        end
        for (int k = 0; k < eth_udp_pkg::FRAME_NIBBLES; k++) begin
            if (k == 0) begin
                @(posedge clk);
            end else begin
                repeat (eth_udp_pkg::TICK_DIVIDER) @(posedge clk);
            end
            #1;
            check_bit("tx_en", tx_en, 1'b1);
            // The checksum nibbles are compared as one field.
            if (k >= CSUM_FIRST_NIBBLE && k <= CSUM_LAST_NIBBLE) begin
                got_csum = {got_csum[11:0], tx_d};
                if (k == CSUM_LAST_NIBBLE) begin
                    check_checksum("ip_checksum", got_csum, exp_csum);
                end
            end else begin
                check_nibble($sformatf("tx_d[%0d]", k), tx_d,
                             exp_frame[eth_udp_pkg::FRAME_BITS - 1 - 4*k -: 4]);
            end
        end
    endtask

    // Measures the gap from tx_en falling to ready rising.
    task automatic wait_gap();
        int unsigned cycles;
        cycles = 0;
        while (tx_en !== 1'b0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 2 * eth_udp_pkg::TICK_DIVIDER) begin
                abort_run("tx_en stayed high after the last nibble.");
            end
        end
        cycles = 0;
        while (ready !== 1'b1) begin
            check_bit("tx_en", tx_en, 1'b0);
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > (eth_udp_pkg::GAP_NIBBLES + 1) * eth_udp_pkg::TICK_DIVIDER) begin
                abort_run("ready did not rise at the end of the interframe gap.");
            end
        end
        if (cycles < (eth_udp_pkg::GAP_NIBBLES - 1) * eth_udp_pkg::TICK_DIVIDER) begin
            abort_run("ready rose before the interframe gap was over.");
        end
    endtask

    task automatic run_frame();
        build_expected();
        start_frame();
        capture_frame();
        wait_gap();
    endtask

    // Idle outputs while send stays high through reset.
    task automatic test_reset_state();
        repeat (20) begin
            @(posedge clk);
            #1;
            check_bit("ready", ready, 1'b1);
            check_bit("tx_en", tx_en, 1'b0);
        end
        @(posedge clk);
        #0.5;
        send = 1'b0;
    endtask

    task automatic test_fixed_frame();
        payload   = 32'hDEADBEEF;
        src_mac   = 48'h02_00_00_00_00_01;
        dest_mac  = 48'hFF_FF_FF_FF_FF_FF;
        src_ip    = 32'hC0A8_0101;
        dest_ip   = 32'hC0A8_01FF;
        src_port  = 16'h1234;
        dest_port = 16'h5678;
        run_frame();
    endtask

    task automatic test_random_frames();
        repeat (5) begin
            randomize_inputs();
            run_frame();
        end
    endtask

    task automatic pulse_send(input int unsigned count);
        repeat (count) begin
            repeat (20) @(posedge clk);
            #0.5;
            send = 1'b1;
            @(posedge clk);
            #0.5;
            send = 1'b0;
        end
    endtask

    // Pulses during a frame and a level held after it start nothing.
    task automatic test_ignored_sends();
        randomize_inputs();
        build_expected();
        start_frame();
        fork
            capture_frame();
            pulse_send(5);
        join
        @(posedge clk);
        #0.5;
        send = 1'b1;
        wait_gap();
        repeat (200) begin
            @(posedge clk);
            #1;
            check_bit("tx_en", tx_en, 1'b0);
            check_bit("ready", ready, 1'b1);
        end
        @(posedge clk);
        #0.5;
        send = 1'b0;
    endtask

    // Inputs change right after the accepted edge.
    task automatic test_latched_inputs();
        randomize_inputs();
        build_expected();
        start_frame();
        randomize_inputs();
        capture_frame();
        wait_gap();
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        reset     = 1'b1;
        send      = 1'b1;
        payload   = '0;
        src_mac   = '0;
        dest_mac  = '0;
        src_ip    = '0;
        dest_ip   = '0;
        src_port  = '0;
        dest_port = '0;
        repeat (3) @(posedge clk);
        #0.5;
        reset = 1'b0;
        test_reset_state();
        test_fixed_frame();
        test_random_frames();
        test_ignored_sends();
        test_latched_inputs();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* udp_frame_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_frame_reg (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           load,
    input  wire                           insert_checksum,
    input  wire                           shift,
    input  wire eth_udp_pkg::payload_t    payload,
    input  wire eth_udp_pkg::mac_addr_t   src_mac,
    input  wire eth_udp_pkg::mac_addr_t   dest_mac,
    input  wire eth_udp_pkg::ip_addr_t    src_ip,
    input  wire eth_udp_pkg::ip_addr_t    dest_ip,
    input  wire eth_udp_pkg::udp_port_t   src_port,
    input  wire eth_udp_pkg::udp_port_t   dest_port,
    input  wire eth_udp_pkg::checksum_t   checksum,
    output eth_udp_pkg::ip_header_t       ip_header,
    output eth_udp_pkg::nibble_t          tx_d
);

    // Whole frame, first nibble on top.
    eth_udp_pkg::frame_t frame;

    // IP header as built at load time.
    eth_udp_pkg::ip_header_t load_header;

    // Checksum field starts as zero.
    assign load_header = {
        eth_udp_pkg::IP_VERSION,
        eth_udp_pkg::IP_IHL,
        eth_udp_pkg::IP_TOS,
        16'(eth_udp_pkg::IP_TOTAL_BYTES),
        eth_udp_pkg::IP_ID,
        eth_udp_pkg::IP_FLAGS,
        eth_udp_pkg::IP_FRAG_OFFSET,
        eth_udp_pkg::IP_TTL,
        eth_udp_pkg::IP_PROTOCOL_UDP,
        16'h0000,
        src_ip,
        dest_ip
    };

    // Load builds the frame and checksum insert patches one field.
    // Shift moves the next nibble to the top.
    always_ff @(posedge clk) begin
        if (load) begin
            frame <= {
                {7{eth_udp_pkg::PREAMBLE_BYTE}},
                eth_udp_pkg::SFD_BYTE,
                dest_mac,
                src_mac,
                eth_udp_pkg::ETHER_TYPE_IPV4,
                load_header,
                src_port,
                dest_port,
                16'(eth_udp_pkg::UDP_TOTAL_BYTES),
                // UDP checksum stays zero.
                16'h0000,
                payload
            };
        end else if (insert_checksum) begin
            frame[eth_udp_pkg::IP_HEADER_LSB + eth_udp_pkg::IP_CHECKSUM_LSB +: 16] <= checksum;
        end else if (shift) begin
            frame <= {frame[eth_udp_pkg::FRAME_BITS-5:0], 4'h0};
        end
    end

    // Header view for the checksum unit; valid until the first shift.
    assign ip_header = frame[eth_udp_pkg::IP_HEADER_LSB +: 8*eth_udp_pkg::IP_HEADER_BYTES];

    // Current nibble on the PHY.
    assign tx_d = frame[eth_udp_pkg::FRAME_BITS-1 -: 4];

    // A new frame must never land while the previous one is shifting.
    load_shift_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(load && shift)
    );

endmodule

`default_nettype wire

/* udp_tx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_tx_ctrl (
    input  wire  clk,
    input  wire  reset,
    input  wire  send,
    input  wire  tick,
    output logic load,
    output logic insert_checksum,
    output logic shift,
    output logic ready,
    output logic tx_en
);

    eth_udp_pkg::tx_state_t     state;
    eth_udp_pkg::nibble_count_t nibble_count;
    eth_udp_pkg::gap_count_t    gap_count;

    // Send edge detection.
    logic send_prev;
    logic send_edge;

    // Starts high so a send held through reset is not an edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            send_prev <= 1'b1;
        end else begin
            send_prev <= send;
        end
    end

    assign send_edge = send && !send_prev;

    // Edges outside idle are dropped.
    assign load = (state == eth_udp_pkg::TX_IDLE) && send_edge;

    // One cycle to register the checksum.
    assign insert_checksum = (state == eth_udp_pkg::TX_CHECKSUM);

    // The first tick only shows nibble 0 and later ticks advance.
    assign shift = (state == eth_udp_pkg::TX_SEND) && tick && tx_en &&
                   (nibble_count != eth_udp_pkg::LAST_NIBBLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= eth_udp_pkg::TX_IDLE;
            ready        <= 1'b1;
            tx_en        <= 1'b0;
            nibble_count <= '0;
            gap_count    <= '0;
        end else begin
            case (state)
                eth_udp_pkg::TX_IDLE: begin
                    if (send_edge) begin
                        ready <= 1'b0;
                        state <= eth_udp_pkg::TX_CHECKSUM;
                    end
                end
                eth_udp_pkg::TX_CHECKSUM: begin
                    state <= eth_udp_pkg::TX_SEND;
                end
                eth_udp_pkg::TX_SEND: begin
                    if (tick) begin
                        if (!tx_en) begin
                            // Frame starts on the PHY.
                            tx_en        <= 1'b1;
                            nibble_count <= '0;
                        end else if (nibble_count == eth_udp_pkg::LAST_NIBBLE) begin
                            // Last nibble has had its full slot.
                            tx_en     <= 1'b0;
                            gap_count <= '0;
                            state     <= eth_udp_pkg::TX_GAP;
                        end else begin
                            nibble_count <= nibble_count + 1'b1;
                        end
                    end
                end
                eth_udp_pkg::TX_GAP: begin
                    if (tick) begin
                        if (gap_count == eth_udp_pkg::LAST_GAP_TICK) begin
                            ready <= 1'b1;
                            state <= eth_udp_pkg::TX_IDLE;
                        end else begin
                            gap_count <= gap_count + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= eth_udp_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // Busy and idle indications never overlap.
    ready_tx_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(ready && tx_en)
    );

endmodule

`default_nettype wire

/* udp_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_tx_top (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         send,
    input  wire eth_udp_pkg::payload_t  payload,
    input  wire eth_udp_pkg::mac_addr_t src_mac,
    input  wire eth_udp_pkg::mac_addr_t dest_mac,
    input  wire eth_udp_pkg::ip_addr_t  src_ip,
    input  wire eth_udp_pkg::ip_addr_t  dest_ip,
    input  wire eth_udp_pkg::udp_port_t src_port,
    input  wire eth_udp_pkg::udp_port_t dest_port,
    output logic                        ready,
    output logic                        tx_en,
    output eth_udp_pkg::nibble_t        tx_d
);

    // PHY slot strobe.
    logic tick;

    // Frame register controls.
    logic load;
    logic insert_checksum;
    logic shift;

    // Checksum loop between the frame register and the adder.
    eth_udp_pkg::ip_header_t ip_header;
    eth_udp_pkg::checksum_t  checksum;

    phy_tick_gen i_tick_gen (
        .clk  (clk),
        .reset(reset),
        .tick (tick)
    );

    udp_tx_ctrl i_ctrl (
        .clk            (clk),
        .reset          (reset),
        .send           (send),
        .tick           (tick),
        .load           (load),
        .insert_checksum(insert_checksum),
        .shift          (shift),
        .ready          (ready),
        .tx_en          (tx_en)
    );

    udp_frame_reg i_frame_reg (
        .clk            (clk),
        .reset          (reset),
        .load           (load),
        .insert_checksum(insert_checksum),
        .shift          (shift),
        .payload        (payload),
        .src_mac        (src_mac),
        .dest_mac       (dest_mac),
        .src_ip         (src_ip),
        .dest_ip        (dest_ip),
        .src_port       (src_port),
        .dest_port      (dest_port),
        .checksum       (checksum),
        .ip_header      (ip_header),
        .tx_d           (tx_d)
    );

    ip_checksum i_checksum (
        .ip_header(ip_header),
        .checksum (checksum)
    );

endmodule

`default_nettype wire
